// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rotor_cipher
FILELIST  = rotor_cipher.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rotor_cipher.f
+incdir+include
verilog/cipher_pkg.sv
verilog/key_scanner.sv
verilog/rotor_stage.sv
verilog/lamp_encoder.sv
verilog/rotor_cipher_top.sv
verification/tb_rotor_cipher.sv

// File: include/cipher_model.svh
`ifndef CIPHER_MODEL_SVH
`define CIPHER_MODEL_SVH

// one pass through a wiring table, the reverse pass found by search
function automatic cipher_pkg::letter_t model_pass(
    input cipher_pkg::letter_t letter,
    input cipher_pkg::wiring_t wiring,
    input bit                  reverse,
    input int                  offset
);
    cipher_pkg::letter_t entry;
    cipher_pkg::letter_t result;
    entry  = cipher_pkg::letter_t'((int'(letter) + offset) % cipher_pkg::NUM_LETTERS);
    result = wiring[entry];
    if (reverse) begin
        for (int i = 0; i < cipher_pkg::NUM_LETTERS; i++) begin
            if (wiring[i] == entry) begin
                result = cipher_pkg::letter_t'(i);
            end
        end
    end
    // back to the fixed frame
    return cipher_pkg::letter_t'((int'(result) + cipher_pkg::NUM_LETTERS - offset)
                                 % cipher_pkg::NUM_LETTERS);
endfunction

// full round trip, right rotor turned by position
function automatic cipher_pkg::letter_t model_encipher(
    input cipher_pkg::letter_t   letter,
    input cipher_pkg::position_t position
);
    cipher_pkg::letter_t l;
    l = model_pass(letter, cipher_pkg::ROTOR_III_WIRING, 1'b0, int'(position));
    l = model_pass(l, cipher_pkg::ROTOR_II_WIRING, 1'b0, 0);
    l = model_pass(l, cipher_pkg::ROTOR_I_WIRING, 1'b0, 0);
    l = model_pass(l, cipher_pkg::REFLECTOR_C_WIRING, 1'b0, 0);
    l = model_pass(l, cipher_pkg::ROTOR_I_WIRING, 1'b1, 0);
    l = model_pass(l, cipher_pkg::ROTOR_II_WIRING, 1'b1, 0);
    l = model_pass(l, cipher_pkg::ROTOR_III_WIRING, 1'b1, int'(position));
    return l;
endfunction

// expected lamp for a sampled key, dark without one
function automatic logic [4:0] model_lamp(
    input bit                    key_seen,
    input bit                    bypass,
    input cipher_pkg::position_t position,
    input cipher_pkg::letter_t   letter
);
    if (!key_seen) begin
        return cipher_pkg::LAMP_DARK;
    end
    if (bypass) begin
        return cipher_pkg::LAMP_CODES[letter];
    end
    return cipher_pkg::LAMP_CODES[model_encipher(letter, position)];
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11, new bit in at the bottom
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// single compare point for every check
task automatic check_value(
    input logic [31:0] actual,
    input logic [31:0] expected,
    input string       what,
    inout int          errors
);
    if (actual !== expected) begin
        errors++;
        $display("error %s: got %0h, expected %0h at %0t", what, actual, expected, $time);
    end
endtask

`endif

// File: verification/tb_rotor_cipher.sv
`timescale 1ns/1ps

module tb_rotor_cipher;
    import cipher_pkg::*;

    `include "cipher_model.svh"

    localparam int TB_SCAN_DIVISOR = 8;
    // scanner, seven stages, lamp encoder
    localparam int PIPE_DEPTH      = 9;
    localparam int BYPASS_KEYS     = 6;
    localparam int CIPHER_KEYS     = 20;
    // each cipher key is followed by its reply key, plus one idle hold
    localparam int TOTAL_KEYS      = BYPASS_KEYS + 2 * CIPHER_KEYS + 1;
    localparam int HOLD_CYCLES     = 3 * NUM_COLUMNS * TB_SCAN_DIVISOR;
    localparam int DRAIN_CYCLES    = 12;
    localparam int WATCHDOG_CYCLES = TOTAL_KEYS * HOLD_CYCLES + 2000;

    // what the lamp should show one pipeline depth after a row sample
    typedef struct packed {
        logic       key_seen;
        logic       enciphered;
        logic       held;
        logic [4:0] lamp;
        logic [4:0] plain_lamp;
    } expect_t;

    logic       CLK100MHZ;
    logic       i_rst;
    logic [3:0] i_rows = 4'd0;
    logic [2:0] i_sw;
    logic [3:0] o_columns;
    logic [4:0] o_lamp_code;
    logic       o_lamp4_n;

    // emulated keyboard
    logic       key_held;
    logic [7:0] held_code;

    logic [15:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    logic [4:0]  reply_lamp = LAMP_DARK;
    expect_t     pending[$];

    // column watch
    logic [3:0] prev_col = 4'd0;
    int         dwell = 0;

    rotor_cipher_top #(
        .SCAN_DIVISOR(TB_SCAN_DIVISOR)
    ) rotor_cipher_top_i (
        .CLK100MHZ  (CLK100MHZ),
        .i_rst      (i_rst),
        .i_rows     (i_rows),
        .i_sw       (i_sw),
        .o_columns  (o_columns),
        .o_lamp_code(o_lamp_code),
        .o_lamp4_n  (o_lamp4_n)
    );

    initial begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    // n bits from the LFSR, one step per bit
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[6:0], lfsr[0]};
        end
        return value;
    endfunction

    // redraw until the index is a letter
    function automatic letter_t random_letter();
        logic [7:0] value;
        value = random_bits(5);
        while (value >= 8'(NUM_LETTERS)) begin
            value = random_bits(5);
        end
        return letter_t'(value);
    endfunction

    // {bypass, position}, switch 0 first, then 1, then 2
    function automatic logic [2:0] switch_mode(input logic [2:0] sw);
        if (sw[0]) begin
            return 3'b000;
        end
        if (sw[1]) begin
            return 3'b001;
        end
        if (sw[2]) begin
            return 3'b010;
        end
        return 3'b100;
    endfunction

    // {seen, letter} from the column and the four rows
    function automatic logic [5:0] decode_key(input logic [3:0] col, input logic [3:0] rows);
        logic [7:0] code;
        logic [5:0] result;
        code   = {col, rows[0], rows[1], rows[2], rows[3]};
        result = '0;
        if (rows != 4'd0) begin
            for (int i = 0; i < NUM_LETTERS; i++) begin
                if (KEY_CODES[i] == code) begin
                    result = {1'b1, 5'(i)};
                end
            end
        end
        return result;
    endfunction

    // rows answer only while the held key's column is driven
    always @(posedge CLK100MHZ) begin
        if (key_held && o_columns == held_code[7:4]) begin
            i_rows <= {held_code[0], held_code[1], held_code[2], held_code[3]};
        end else begin
            i_rows <= 4'd0;
        end
    end

    // scoreboard, pre-edge values are what the DUT samples
    always @(posedge CLK100MHZ) begin
        expect_t    entry;
        expect_t    due;
        logic [5:0] key;
        logic [2:0] mode;
        key              = decode_key(o_columns, i_rows);
        mode             = switch_mode(i_sw);
        entry.key_seen   = key[5] && !i_rst;
        entry.enciphered = entry.key_seen && !mode[2];
        entry.held       = entry.key_seen && key_held &&
                           ({o_columns, i_rows[0], i_rows[1], i_rows[2], i_rows[3]} == held_code);
        entry.lamp       = model_lamp(entry.key_seen, mode[2], mode[1:0], key[4:0]);
        entry.plain_lamp = LAMP_CODES[key[4:0]];
        pending.push_back(entry);
        if (pending.size() > PIPE_DEPTH) begin
            due = pending.pop_front();
            checks++;
            check_value(o_lamp_code, due.lamp, "o_lamp_code", errors);
            check_value({4'd0, o_lamp4_n}, {4'd0, ~due.lamp[4]}, "o_lamp4_n", errors);
            // reflector has no fixed points
            if (due.enciphered && o_lamp_code == due.plain_lamp) begin
                errors++;
                $display("error: an enciphered key lit its own lamp at %0t", $time);
            end
            if (due.held) begin
                reply_lamp = o_lamp_code;
            end
        end
    end

    // column order and dwell
    always @(posedge CLK100MHZ) begin
        logic [3:0] next_col;
        next_col = (prev_col == 4'(NUM_COLUMNS - 1)) ? 4'd0 : prev_col + 4'd1;
        if (i_rst) begin
            prev_col = 4'd0;
            dwell    = 0;
        end else if (o_columns == prev_col) begin
            dwell++;
        end else begin
            checks++;
            check_value({1'b0, o_columns}, {1'b0, next_col}, "o_columns", errors);
            check_value(dwell, TB_SCAN_DIVISOR, "o_columns dwell", errors);
            prev_col = o_columns;
            dwell    = 1;
        end
    end

    // three scan rounds with one key, then empty the pipeline
    task automatic hold_key(input bit present, input letter_t letter, input logic [2:0] sw);
        @(posedge CLK100MHZ);
        reply_lamp = LAMP_DARK;
        key_held  <= present;
        held_code <= KEY_CODES[letter];
        i_sw      <= sw;
        repeat (HOLD_CYCLES) @(posedge CLK100MHZ);
        key_held <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge CLK100MHZ);
    endtask

    initial begin
        letter_t    plain;
        letter_t    reply;
        logic [2:0] sw;
        logic [2:0] mode;
        i_rst     = 1'b1;
        i_sw      = 3'd0;
        key_held  = 1'b0;
        held_code = 8'd0;
        lfsr      = 16'd38764;
        repeat (4) @(posedge CLK100MHZ);
        i_rst <= 1'b0;

        // straight out of reset
        @(negedge CLK100MHZ);
        check_value(o_lamp_code, LAMP_DARK, "o_lamp_code", errors);
        check_value({1'b0, o_columns}, 5'd0, "o_columns", errors);
        check_value({4'd0, o_lamp4_n}, 5'd0, "o_lamp4_n", errors);

        // plain typing lights the key itself
        for (int n = 0; n < BYPASS_KEYS; n++) begin
            plain = random_letter();
            hold_key(1'b1, plain, 3'b000);
            check_value(reply_lamp, LAMP_CODES[plain], "o_lamp_code bypass", errors);
        end

        // nothing pressed, the scoreboard expects a dark lamp throughout
        hold_key(1'b0, 5'd0, 3'b001);

        for (int n = 0; n < CIPHER_KEYS; n++) begin
            // any nonzero switch pattern, priority picks the position
            sw = 3'(random_bits(3));
            while (sw == 3'd0) begin
                sw = 3'(random_bits(3));
            end
            mode  = switch_mode(sw);
            plain = random_letter();
            hold_key(1'b1, plain, sw);
            reply = model_encipher(plain, mode[1:0]);
            check_value(reply_lamp, LAMP_CODES[reply], "o_lamp_code cipher", errors);
            // typing the answer back gives the original key
            hold_key(1'b1, reply, sw);
            check_value(reply_lamp, LAMP_CODES[plain], "o_lamp_code reply", errors);
        end

        repeat (PIPE_DEPTH + 2) @(posedge CLK100MHZ);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // run length bound by the number of key holds
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK100MHZ);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verilog/cipher_pkg.sv
package cipher_pkg;

    // alphabet size and scan geometry
    localparam int NUM_LETTERS = 26;
    localparam int NUM_COLUMNS = 10;

    // board scan pace, 10 ms per column at 100 MHz
    localparam int SCAN_DIVISOR_DEFAULT = 1_000_000;

    // letter index, A is 0 and Z is 25
    typedef logic [4:0] letter_t;

    // right rotor position from the switches
    typedef logic [1:0] position_t;

    // entry i holds the letter that input letter i leaves as
    typedef letter_t [0:NUM_LETTERS-1] wiring_t;

    // one pipeline word
    typedef struct packed {
        logic      valid;
        logic      bypass;
        position_t position;
        letter_t   letter;
    } cipher_word_t;

    // BDFHJLCPRTXVZNYEIWGAKMUSQO
    localparam wiring_t ROTOR_III_WIRING = '{
        5'd1,  5'd3,  5'd5,  5'd7,  5'd9,  5'd11, 5'd2,  5'd15, 5'd17,
        5'd19, 5'd23, 5'd21, 5'd25, 5'd13, 5'd24, 5'd4,  5'd8,  5'd22,
        5'd6,  5'd0,  5'd10, 5'd12, 5'd20, 5'd18, 5'd16, 5'd14
    };

    // AJDKSIRUXBLHWTMCQGZNPYFVOE
    localparam wiring_t ROTOR_II_WIRING = '{
        5'd0,  5'd9,  5'd3,  5'd10, 5'd18, 5'd8,  5'd17, 5'd20, 5'd23,
        5'd1,  5'd11, 5'd7,  5'd22, 5'd19, 5'd12, 5'd2,  5'd16, 5'd6,
        5'd25, 5'd13, 5'd15, 5'd24, 5'd5,  5'd21, 5'd14, 5'd4
    };

    // EKMFLGDQVZNTOWYHXUSPAIBRCJ
    localparam wiring_t ROTOR_I_WIRING = '{
        5'd4,  5'd10, 5'd12, 5'd5,  5'd11, 5'd6,  5'd3,  5'd16, 5'd21,
        5'd25, 5'd13, 5'd19, 5'd14, 5'd22, 5'd24, 5'd7,  5'd23, 5'd20,
        5'd18, 5'd15, 5'd0,  5'd8,  5'd1,  5'd17, 5'd2,  5'd9
    };

    // FVPJIAOYEDRZXWGCTKUQSBNMHL, pairs only, no letter maps to itself
    localparam wiring_t REFLECTOR_C_WIRING = '{
        5'd5,  5'd21, 5'd15, 5'd9,  5'd8,  5'd0,  5'd14, 5'd24, 5'd4,
        5'd3,  5'd17, 5'd25, 5'd23, 5'd22, 5'd6,  5'd2,  5'd19, 5'd10,
        5'd20, 5'd16, 5'd18, 5'd1,  5'd13, 5'd12, 5'd7,  5'd11
    };

    // {column, row0, row1, row2, row3} per letter A to Z
    localparam logic [0:NUM_LETTERS-1][7:0] KEY_CODES = '{
        8'h14, 8'h52, 8'h32, 8'h34, 8'h28, 8'h44, 8'h54, 8'h64, 8'h78,
        8'h74, 8'h84, 8'h82, 8'h72, 8'h62, 8'h88, 8'h02, 8'h08, 8'h38,
        8'h24, 8'h48, 8'h68, 8'h42, 8'h18, 8'h22, 8'h12, 8'h58
    };

    // lamp board skips 13 to 15 between M and N
    localparam logic [0:NUM_LETTERS-1][4:0] LAMP_CODES = '{
        5'd0,  5'd1,  5'd2,  5'd3,  5'd4,  5'd5,  5'd6,  5'd7,  5'd8,
        5'd9,  5'd10, 5'd11, 5'd12, 5'd16, 5'd17, 5'd18, 5'd19, 5'd20,
        5'd21, 5'd22, 5'd23, 5'd24, 5'd25, 5'd26, 5'd27, 5'd28
    };

    // all lamps off
    localparam logic [4:0] LAMP_DARK = 5'd31;

    // add a small signed amount modulo 26, letter assumed in range
    function automatic letter_t rotate_letter(letter_t letter, int amount);
        int sum;
        sum = int'(letter) + amount;
        if (sum >= NUM_LETTERS) begin
            sum = sum - NUM_LETTERS;
        end else if (sum < 0) begin
            sum = sum + NUM_LETTERS;
        end
        return letter_t'(sum);
    endfunction

    // return path through a rotor
    function automatic wiring_t invert_wiring(wiring_t wiring);
        wiring_t inverse;
        inverse = '0;
        for (int i = 0; i < NUM_LETTERS; i++) begin
            inverse[wiring[i]] = letter_t'(i);
        end
        return inverse;
    endfunction

endpackage

// File: verilog/key_scanner.sv
`timescale 1ns/1ps

module key_scanner #(
    parameter int SCAN_DIVISOR = cipher_pkg::SCAN_DIVISOR_DEFAULT
) (
    input  logic                     CLK100MHZ,
    input  logic                     i_rst,
    input  logic [3:0]               i_rows,
    input  logic [2:0]               i_sw,
    output logic [3:0]               o_columns,
    output cipher_pkg::cipher_word_t o_word
);
    import cipher_pkg::*;

    // divider wide enough for SCAN_DIVISOR - 1
    logic [$clog2(SCAN_DIVISOR + 1)-1:0] div_count;
    logic                                col_step;

    // current column plus rows, row 0 on the high side
    logic [7:0] scan_code;
    logic       hit;
    letter_t    hit_letter;

    // mode from the switches
    logic       sw_bypass;
    position_t  sw_position;

    assign col_step  = (int'(div_count) == SCAN_DIVISOR - 1);
    assign scan_code = {o_columns, i_rows[0], i_rows[1], i_rows[2], i_rows[3]};

    // column pacing
    always_ff @(posedge CLK100MHZ) begin
        if (i_rst) begin
            div_count <= '0;
            o_columns <= '0;
        end else if (col_step) begin
            div_count <= '0;
            // wrap after the last column
            if (o_columns == 4'(NUM_COLUMNS - 1)) begin
                o_columns <= '0;
            end else begin
                o_columns <= o_columns + 4'd1;
            end
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // key code table search, only with some row pulled high
    always_comb begin
        hit        = 1'b0;
        hit_letter = '0;
        if (|i_rows) begin
            for (int i = 0; i < NUM_LETTERS; i++) begin
                if (KEY_CODES[i] == scan_code) begin
                    hit        = 1'b1;
                    hit_letter = letter_t'(i);
                end
            end
        end
    end

    // switch 0 wins over 1, 1 over 2
    always_comb begin
        sw_bypass   = 1'b0;
        sw_position = '0;
        if (i_sw[0]) begin
            sw_position = 2'd0;
        end else if (i_sw[1]) begin
            sw_position = 2'd1;
        end else if (i_sw[2]) begin
            sw_position = 2'd2;
        end else begin
            // plain typing, no cipher
            sw_bypass = 1'b1;
        end
    end

    // one word per sampled cycle
    always_ff @(posedge CLK100MHZ) begin
        o_word.letter   <= hit_letter;
        o_word.position <= sw_position;
        o_word.bypass   <= sw_bypass;
        if (i_rst) begin
            o_word.valid <= 1'b0;
        end else begin
            o_word.valid <= hit;
        end
    end

    // column count stays on the board's ten columns
    a_column_range: assert property (
        @(posedge CLK100MHZ) disable iff (i_rst)
        o_columns <= 4'(NUM_COLUMNS - 1)
    );

endmodule

// File: verilog/lamp_encoder.sv
`timescale 1ns/1ps

module lamp_encoder (
    input  logic                     CLK100MHZ,
    input  logic                     i_rst,
    input  cipher_pkg::cipher_word_t i_word,
    output logic [4:0]               o_lamp_code,
    output logic                     o_lamp4_n
);
    import cipher_pkg::*;

    // code for the board, dark between keys
    logic [4:0] lamp_next;

    always_comb begin
        if (i_word.valid) begin
            lamp_next = LAMP_CODES[i_word.letter];
        end else begin
            lamp_next = LAMP_DARK;
        end
    end

    // lamp driver wants bit 4 on two pins, one inverted
    always_ff @(posedge CLK100MHZ) begin
        if (i_rst) begin
            o_lamp_code <= LAMP_DARK;
            o_lamp4_n   <= 1'b0;
        end else begin
            o_lamp_code <= lamp_next;
            o_lamp4_n   <= ~lamp_next[4];
        end
    end

endmodule

// File: verilog/rotor_cipher_top.sv
`timescale 1ns/1ps

module rotor_cipher_top #(
    parameter int SCAN_DIVISOR = cipher_pkg::SCAN_DIVISOR_DEFAULT
) (
    input  logic       CLK100MHZ,
    input  logic       i_rst,
    input  logic [3:0] i_rows,
    input  logic [2:0] i_sw,
    output logic [3:0] o_columns,
    output logic [4:0] o_lamp_code,
    output logic       o_lamp4_n
);
    import cipher_pkg::*;

    // word 0 from the scanner, words 1 to 7 after each stage
    cipher_word_t stage_words [0:7];

    key_scanner #(
        .SCAN_DIVISOR(SCAN_DIVISOR)
    ) key_scanner_i (
        .CLK100MHZ(CLK100MHZ),
        .i_rst    (i_rst),
        .i_rows   (i_rows),
        .i_sw     (i_sw),
        .o_columns(o_columns),
        .o_word   (stage_words[0])
    );

    // right rotor in, turned by the switch position
    rotor_stage #(
        .WIRING(ROTOR_III_WIRING), .REVERSE(1'b0), .OFFSET_BY_POSITION(1'b1)
    ) rotor_iii_fwd_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[0]), .o_word(stage_words[1])
    );

    rotor_stage #(
        .WIRING(ROTOR_II_WIRING), .REVERSE(1'b0), .OFFSET_BY_POSITION(1'b0)
    ) rotor_ii_fwd_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[1]), .o_word(stage_words[2])
    );

    rotor_stage #(
        .WIRING(ROTOR_I_WIRING), .REVERSE(1'b0), .OFFSET_BY_POSITION(1'b0)
    ) rotor_i_fwd_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[2]), .o_word(stage_words[3])
    );

    // reflector C turns the signal around
    rotor_stage #(
        .WIRING(REFLECTOR_C_WIRING), .REVERSE(1'b0), .OFFSET_BY_POSITION(1'b0)
    ) reflector_c_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[3]), .o_word(stage_words[4])
    );

    // way back out, inverse wiring
    rotor_stage #(
        .WIRING(ROTOR_I_WIRING), .REVERSE(1'b1), .OFFSET_BY_POSITION(1'b0)
    ) rotor_i_rev_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[4]), .o_word(stage_words[5])
    );

    rotor_stage #(
        .WIRING(ROTOR_II_WIRING), .REVERSE(1'b1), .OFFSET_BY_POSITION(1'b0)
    ) rotor_ii_rev_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[5]), .o_word(stage_words[6])
    );

    rotor_stage #(
        .WIRING(ROTOR_III_WIRING), .REVERSE(1'b1), .OFFSET_BY_POSITION(1'b1)
    ) rotor_iii_rev_i (
        .CLK100MHZ(CLK100MHZ), .i_rst(i_rst), .i_word(stage_words[6]), .o_word(stage_words[7])
    );

    lamp_encoder lamp_encoder_i (
        .CLK100MHZ  (CLK100MHZ),
        .i_rst      (i_rst),
        .i_word     (stage_words[7]),
        .o_lamp_code(o_lamp_code),
        .o_lamp4_n  (o_lamp4_n)
    );

endmodule

// File: verilog/rotor_stage.sv
`timescale 1ns/1ps

module rotor_stage #(
    parameter cipher_pkg::wiring_t WIRING             = cipher_pkg::ROTOR_I_WIRING,
    parameter bit                  REVERSE            = 1'b0,
    parameter bit                  OFFSET_BY_POSITION = 1'b0
) (
    input  logic                     CLK100MHZ,
    input  logic                     i_rst,
    input  cipher_pkg::cipher_word_t i_word,
    output cipher_pkg::cipher_word_t o_word
);
    import cipher_pkg::*;

    // table for this direction
    wiring_t   stage_table;
    position_t offset;

    // letter before the table, after it, and back in the fixed frame
    letter_t   entry_letter;
    letter_t   mapped_letter;
    letter_t   exit_letter;

    // reverse stages walk the wiring backwards
    assign stage_table = REVERSE ? invert_wiring(WIRING) : WIRING;

    // only the right rotor sits turned by the switch position
    assign offset = OFFSET_BY_POSITION ? i_word.position : 2'd0;

    always_comb begin
        // shift into the rotor frame
        entry_letter  = rotate_letter(i_word.letter, int'(offset));
        mapped_letter = stage_table[entry_letter];
        // and back out
        exit_letter   = rotate_letter(mapped_letter, -int'(offset));
    end

    always_ff @(posedge CLK100MHZ) begin
        o_word.bypass   <= i_word.bypass;
        o_word.position <= i_word.position;
        // bypass words keep their letter through every stage
        if (i_word.bypass) begin
            o_word.letter <= i_word.letter;
        end else begin
            o_word.letter <= exit_letter;
        end
        if (i_rst) begin
            o_word.valid <= 1'b0;
        end else begin
            o_word.valid <= i_word.valid;
        end
    end

    // the stage before must hand over a real letter
    a_letter_in_range: assert property (
        @(posedge CLK100MHZ) disable iff (i_rst)
        i_word.valid |-> (i_word.letter < letter_t'(NUM_LETTERS))
    );

endmodule
